/* logic/dispatch.sv */
`timescale 1ns/1ps

module dispatch import dispatch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  instr_t   instr,
    input  logic     ihit,
    input  logic     freeze,
    input  logic     flush,
    input  logic     busy_alu,
    input  logic     busy_ldst,
    input  logic     busy_branch,
    input  logic     busy_ldst_m,
    input  logic     busy_gemm,
    input  logic     wb_s_en,
    input  s_reg_t   wb_s_sel,
    input  logic     wb_m_en,
    input  m_reg_t   wb_m_sel,
    output logic     stall,
    output logic     out_valid,
    output fu_t      out_fu,
    output aluop_t   out_alu_op,
    output imm_t     out_imm,
    output logic [4:0] out_rd,
    output logic [4:0] out_rs1,
    output logic [4:0] out_rs2,
    output logic [4:0] out_rs3,
    output src_tag_t out_t1,
    output src_tag_t out_t2,
    output src_tag_t out_t3,
    output logic     out_m_dest
);

    fu_t    fu;
    s_reg_t s_rd, s_rs1, s_rs2;
    m_reg_t m_rd, m_rs1, m_rs2, m_rs3;
    imm_t   imm;
    aluop_t alu_op;
    logic   s_write, m_write, is_load;

    logic [S_NREGS-1:0] s_pend, s_tag;
    logic [M_NREGS-1:0] m_pend, m_tag;

    logic fu_busy, waw, hazard, accept;

    logic [4:0] n_rd, n_rs1, n_rs2, n_rs3;
    src_tag_t   n_t1, n_t2, n_t3;

    // stale load bit is hidden once the entry clears
    function automatic src_tag_t mk_tag(input logic p, input logic t);
        return p ? {1'b1, t} : 2'b00;
    endfunction

    instr_decoder i_dec (
        .instr  (instr),
        .fu     (fu),
        .s_rd   (s_rd),
        .s_rs1  (s_rs1),
        .s_rs2  (s_rs2),
        .m_rd   (m_rd),
        .m_rs1  (m_rs1),
        .m_rs2  (m_rs2),
        .m_rs3  (m_rs3),
        .imm    (imm),
        .alu_op (alu_op),
        .s_write(s_write),
        .m_write(m_write),
        .is_load(is_load)
    );

    reg_status_table #(.NREGS(S_NREGS)) s_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .di_write(accept & s_write),
        .di_sel  (s_rd),
        .di_tag  (is_load),
        .wb_write(wb_s_en),
        .wb_sel  (wb_s_sel),
        .pending (s_pend),
        .tag     (s_tag)
    );

    reg_status_table #(.NREGS(M_NREGS)) m_rst (
        .CLK     (CLK),
        .nRST    (nRST),
        .di_write(accept & m_write),
        .di_sel  (m_rd),
        .di_tag  (is_load),
        .wb_write(wb_m_en),
        .wb_sel  (wb_m_sel),
        .pending (m_pend),
        .tag     (m_tag)
    );

    always_comb begin
        case (fu)
            FU_ALU:    fu_busy = busy_alu;
            FU_LDST:   fu_busy = busy_ldst;
            FU_BRANCH: fu_busy = busy_branch;
            FU_LDST_M: fu_busy = busy_ldst_m;
            FU_GEMM:   fu_busy = busy_gemm;
            default:   fu_busy = 1'b0;
        endcase
    end

    assign waw    = (s_write & s_pend[s_rd]) | (m_write & m_pend[m_rd]);
    assign hazard = fu_busy | waw;
    assign stall  = ihit & hazard;
    assign accept = ihit & ~flush & ~freeze & ~hazard & (fu != FU_NONE);

    // source fields and tags, read before this edge's table updates
    always_comb begin
        n_rd  = {1'b0, m_rd};
        n_rs1 = '0;
        n_rs2 = '0;
        n_rs3 = '0;
        n_t1  = '0;
        n_t2  = '0;
        n_t3  = '0;
        case (fu)
            FU_LDST_M: begin // scalar base only
                n_rs1 = s_rs1;
                n_t1  = mk_tag(s_pend[s_rs1], s_tag[s_rs1]);
            end
            FU_GEMM: begin
                n_rs1 = {1'b0, m_rs1};
                n_rs2 = {1'b0, m_rs2};
                n_rs3 = {1'b0, m_rs3};
                n_t1  = mk_tag(m_pend[m_rs1], m_tag[m_rs1]);
                n_t2  = mk_tag(m_pend[m_rs2], m_tag[m_rs2]);
                n_t3  = mk_tag(m_pend[m_rs3], m_tag[m_rs3]);
            end
            default: begin
                n_rd  = s_rd;
                n_rs1 = s_rs1;
                n_rs2 = s_rs2;
                n_t1  = mk_tag(s_pend[s_rs1], s_tag[s_rs1]);
                n_t2  = mk_tag(s_pend[s_rs2], s_tag[s_rs2]);
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid  <= 1'b0;
            out_fu     <= FU_NONE;
            out_alu_op <= '0;
            out_imm    <= '0;
            out_rd     <= '0;
            out_rs1    <= '0;
            out_rs2    <= '0;
            out_rs3    <= '0;
            out_t1     <= '0;
            out_t2     <= '0;
            out_t3     <= '0;
            out_m_dest <= 1'b0;
        end else if (flush) begin
            out_valid  <= 1'b0;
            out_fu     <= FU_NONE;
            out_alu_op <= '0;
            out_imm    <= '0;
            out_rd     <= '0;
            out_rs1    <= '0;
            out_rs2    <= '0;
            out_rs3    <= '0;
            out_t1     <= '0;
            out_t2     <= '0;
            out_t3     <= '0;
            out_m_dest <= 1'b0;
        end else if (accept) begin
            out_valid  <= 1'b1;
            out_fu     <= fu;
            out_alu_op <= alu_op;
            out_imm    <= imm;
            out_rd     <= n_rd;
            out_rs1    <= n_rs1;
            out_rs2    <= n_rs2;
            out_rs3    <= n_rs3;
            out_t1     <= n_t1;
            out_t2     <= n_t2;
            out_t3     <= n_t3;
            out_m_dest <= (fu == FU_LDST_M) | (fu == FU_GEMM);
        end else begin
            out_valid  <= 1'b0; // freeze, hazard or idle, fields hold
        end
    end

endmodule

/* logic/dispatch_pkg.sv */
package dispatch_pkg;

    // register file sizes
    localparam int S_NREGS = 32;
    localparam int M_NREGS = 16;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  s_reg_t;
    typedef logic [3:0]  m_reg_t;
    typedef logic [15:0] imm_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  fu_t;
    typedef logic [3:0]  aluop_t;

    // [1] source pending, [0] producer is a load
    typedef logic [1:0]  src_tag_t;

    // instruction word layout
    //   opcode       [6:0]
    //   scalar rd    [11:7]   rs1 [19:15]   rs2 [24:20]
    //   matrix rd    [31:28]  rs1 [27:24]   rs2 [23:20]   rs3 [19:16]
    //   immediate    [15:0]
    //   alu op       {[30], [14:12]}

    localparam opcode_t OP_ALU    = 7'b0110011; // scalar write
    localparam opcode_t OP_LOAD   = 7'b0000011; // scalar write, load tag
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_MLOAD  = 7'b0000111; // matrix write, scalar base in rs1
    localparam opcode_t OP_MSTORE = 7'b0100111;
    localparam opcode_t OP_GEMM   = 7'b1110111; // matrix write, three matrix sources

    // functional unit codes
    localparam fu_t FU_NONE   = 3'd0;
    localparam fu_t FU_ALU    = 3'd1;
    localparam fu_t FU_LDST   = 3'd2;
    localparam fu_t FU_BRANCH = 3'd3;
    localparam fu_t FU_LDST_M = 3'd4;
    localparam fu_t FU_GEMM   = 3'd5;

endpackage

/* logic/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top import dispatch_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  instr_t   instr,
    input  logic     ihit,
    input  logic     freeze,
    input  logic     flush,
    input  logic     busy_alu,
    input  logic     busy_ldst,
    input  logic     busy_branch,
    input  logic     busy_ldst_m,
    input  logic     busy_gemm,
    input  logic     wb_s_en,
    input  s_reg_t   wb_s_sel,
    input  logic     wb_m_en,
    input  m_reg_t   wb_m_sel,
    output logic     stall,
    output logic     out_valid,
    output fu_t      out_fu,
    output aluop_t   out_alu_op,
    output imm_t     out_imm,
    output logic [4:0] out_rd,
    output logic [4:0] out_rs1,
    output logic [4:0] out_rs2,
    output logic [4:0] out_rs3,
    output src_tag_t out_t1,
    output src_tag_t out_t2,
    output src_tag_t out_t3,
    output logic     out_m_dest
);

    // port names match one to one
    dispatch i_dispatch (.*);

endmodule

/* logic/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder import dispatch_pkg::*; (
    input  instr_t instr,
    output fu_t    fu,
    output s_reg_t s_rd,
    output s_reg_t s_rs1,
    output s_reg_t s_rs2,
    output m_reg_t m_rd,
    output m_reg_t m_rs1,
    output m_reg_t m_rs2,
    output m_reg_t m_rs3,
    output imm_t   imm,
    output aluop_t alu_op,
    output logic   s_write,
    output logic   m_write,
    output logic   is_load
);

    opcode_t op;

    assign op = instr[6:0];

    // field slicing is unconditional, unit logic picks what it needs
    assign s_rd   = instr[11:7];
    assign s_rs1  = instr[19:15];
    assign s_rs2  = instr[24:20];
    assign m_rd   = instr[31:28];
    assign m_rs1  = instr[27:24];
    assign m_rs2  = instr[23:20];
    assign m_rs3  = instr[19:16];
    assign imm    = instr[15:0];
    assign alu_op = {instr[30], instr[14:12]};

    always_comb begin
        fu      = FU_NONE;
        s_write = 1'b0;
        m_write = 1'b0;
        is_load = 1'b0;
        case (op)
            OP_ALU: begin
                fu      = FU_ALU;
                s_write = 1'b1;
            end
            OP_LOAD: begin
                fu      = FU_LDST;
                s_write = 1'b1;
                is_load = 1'b1;
            end
            OP_STORE:  fu = FU_LDST;
            OP_BRANCH: fu = FU_BRANCH;
            OP_MLOAD: begin
                fu      = FU_LDST_M;
                m_write = 1'b1;
                is_load = 1'b1;
            end
            OP_MSTORE: fu = FU_LDST_M;
            OP_GEMM: begin
                fu      = FU_GEMM;
                m_write = 1'b1;
            end
            default:   fu = FU_NONE; // illegal, never dispatched
        endcase
    end

endmodule

/* logic/reg_status_table.sv */
`timescale 1ns/1ps

module reg_status_table import dispatch_pkg::*; #(
    parameter int NREGS = S_NREGS
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic                     di_write,
    input  logic [$clog2(NREGS)-1:0] di_sel,
    input  logic                     di_tag,
    input  logic                     wb_write,
    input  logic [$clog2(NREGS)-1:0] wb_sel,
    output logic [NREGS-1:0]         pending,
    output logic [NREGS-1:0]         tag
);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pending <= '0;
            tag     <= '0;
        end else begin
            if (wb_write) begin
                pending[wb_sel] <= 1'b0;
            end
            // dispatch after writeback so a same-entry collision stays pending
            if (di_write) begin
                pending[di_sel] <= 1'b1;
                tag[di_sel]     <= di_tag;
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dispatch_tb \
    -f src.f -o dispatch_sim
./obj_dir/dispatch_sim | tee sim.log

# the run passes only if the pass line made it into the log
grep -q '^>>> PASS$' sim.log

/* src.f */
logic/dispatch_pkg.sv
logic/instr_decoder.sv
logic/reg_status_table.sv
logic/dispatch.sv
logic/dispatch_top.sv
testbench/dispatch_chk.sv
testbench/dispatch_tb.sv

/* testbench/dispatch_chk.sv */
`timescale 1ns/1ps

module dispatch_chk import dispatch_pkg::*; (
    input logic               CLK,
    input logic               nRST,
    input logic               flush,
    input logic               stall,
    input logic               out_valid,
    input logic [S_NREGS-1:0] s_pend,
    input logic [M_NREGS-1:0] m_pend
);

    // a squashed slot never shows up at issue
    a_flush_kill: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !out_valid)
        else $error("out_valid set in the cycle after a flush");

    // a stalled word sets no new pending bit in either table
    a_stall_no_write: assert property (@(posedge CLK) disable iff (!nRST)
        stall |=> ((s_pend & ~$past(s_pend)) == '0) && ((m_pend & ~$past(m_pend)) == '0))
        else $error("status table written while the stage stalls");

    a_reset_idle: assert property (@(posedge CLK) !nRST |=> !out_valid)
        else $error("out_valid set right after reset");

endmodule

bind dispatch dispatch_chk i_dispatch_chk (
    .CLK      (CLK),
    .nRST     (nRST),
    .flush    (flush),
    .stall    (stall),
    .out_valid(out_valid),
    .s_pend   (s_pend),
    .m_pend   (m_pend)
);

/* testbench/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb import dispatch_pkg::*; ();

    localparam int    RESET_CYCLES = 16;
    localparam int    MARGIN       = 20;
    localparam string DATA_FILE    = "testbench/dispatch_testdata.txt";

    logic       CLK, nRST, ihit, freeze, flush;
    instr_t     instr;
    logic       busy_alu, busy_ldst, busy_branch, busy_ldst_m, busy_gemm;
    logic       wb_s_en, wb_m_en;
    s_reg_t     wb_s_sel;
    m_reg_t     wb_m_sel;
    logic       stall, out_valid, out_m_dest;
    fu_t        out_fu;
    aluop_t     out_alu_op;
    imm_t       out_imm;
    logic [4:0] out_rd, out_rs1, out_rs2, out_rs3;
    src_tag_t   out_t1, out_t2, out_t3;

    int          nvec   = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit  = 0; // armed once the vectors are counted
    logic [31:0] lfsr   = 32'h4e07;

    dispatch_top i_dispatch_top (.*);

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the vectors never completed", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // {rs1, rs2, rs3} as the issue side should see them
    function automatic logic [14:0] source_fields(input logic [31:0] w, input fu_t fu);
        case (fu)
            FU_LDST_M: return {w[19:15], 5'd0, 5'd0}; // scalar base only
            FU_GEMM:   return {1'b0, w[27:24], 1'b0, w[23:20], 1'b0, w[19:16]};
            default:   return {w[19:15], w[24:20], 5'd0};
        endcase
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s %s expected %0h actual %0h", test, field, exp, act);
        end
    endtask

    task automatic count_vectors(input int fd);
        string       line;
        logic [31:0] word;
        while ($fgets(line, fd) != 0) begin
            if (line.substr(0, 1) != "//" && $sscanf(line, "%h", word) == 1) begin
                nvec++;
            end
        end
    endtask

    task automatic run_vectors(input int fd);
        string       line, name;
        int          n;
        logic [31:0] w, ih, fz, fl, bz, us, se, ss, me, ms;
        logic [31:0] e_stall, e_valid, e_fu, e_rd, e_t1, e_t2, e_t3;
        logic        e_m_dest;
        while ($fgets(line, fd) != 0) begin
            n = 0;
            if (line.substr(0, 1) != "//") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %s",
                            w, ih, fz, fl, bz, us, se, ss, me, ms,
                            e_stall, e_valid, e_fu, e_rd, e_t1, e_t2, e_t3, name);
            end
            if (n == 18) begin
                // background busy on units the line leaves alone
                for (int b = 0; b < 5; b++) begin
                    if (e_valid[0] == 1'b0 && us[b] == 1'b0) begin
                        lfsr  = lfsr_step(lfsr);
                        bz[b] = lfsr[0];
                    end
                end
                instr = w;
                {flush, freeze, ihit} = {fl[0], fz[0], ih[0]};
                {busy_gemm, busy_ldst_m, busy_branch, busy_ldst, busy_alu} = bz[4:0];
                {wb_s_en, wb_s_sel} = {se[0], ss[4:0]};
                {wb_m_en, wb_m_sel} = {me[0], ms[3:0]};
                #40;
                check_value(name, "stall", e_stall, 32'(stall));
                @(posedge CLK);
                @(negedge CLK); // record is stable here
                check_value(name, "out_valid", e_valid, 32'(out_valid));
                check_value(name, "out_fu", e_fu, 32'(out_fu));
                check_value(name, "out_rd", e_rd, 32'(out_rd));
                check_value(name, "out_t1", e_t1, 32'(out_t1));
                check_value(name, "out_t2", e_t2, 32'(out_t2));
                check_value(name, "out_t3", e_t3, 32'(out_t3));
                if (e_valid[0]) begin
                    e_m_dest = (e_fu[2:0] == FU_LDST_M) || (e_fu[2:0] == FU_GEMM);
                    check_value(name, "out_imm", {16'h0, w[15:0]}, 32'(out_imm));
                    check_value(name, "out_alu_op", {28'h0, w[30], w[14:12]},
                                32'(out_alu_op));
                    check_value(name, "out_m_dest", 32'(e_m_dest), 32'(out_m_dest));
                    check_value(name, "out_rs", 32'(source_fields(w, e_fu[2:0])),
                                32'({out_rs1, out_rs2, out_rs3}));
                end
            end
        end
    endtask

    initial begin
        int fd;
        CLK  = 1'b0;
        nRST = 1'b0;
        instr = '0;
        {ihit, freeze, flush} = '0;
        {busy_gemm, busy_ldst_m, busy_branch, busy_ldst, busy_alu} = '0;
        {wb_s_en, wb_s_sel, wb_m_en, wb_m_sel} = '0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", DATA_FILE);
            errors++;
        end else begin
            count_vectors(fd);
            $fclose(fd);
            if (nvec == 0) begin
                $display("no test vectors found in %s", DATA_FILE);
                errors++;
            end
            limit = nvec + RESET_CYCLES + MARGIN;
            repeat (RESET_CYCLES) @(posedge CLK);
            @(negedge CLK);
            nRST = 1'b1;
            check_value("reset", "stall", 0, 32'(stall));
            check_value("reset", "out_valid", 0, 32'(out_valid));
            check_value("reset", "record", 0, 32'({out_fu, out_alu_op, out_imm, out_m_dest}));
            check_value("reset", "sources", 0,
                        32'({out_rd, out_rs1, out_rs2, out_rs3, out_t1, out_t2, out_t3}));
            fd = $fopen(DATA_FILE, "r");
            run_vectors(fd);
            $fclose(fd);
        end
        $display("vectors %0d  checks %0d  errors %0d", nvec, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* testbench/dispatch_testdata.txt */
// instr ihit freeze flush busy use wbs_en wbs_sel wbm_en wbm_sel | exp: stall valid fu rd t1 t2 t3 name
// all hex; busy and use bit0 alu, bit1 ldst, bit2 branch, bit3 ldst_m, bit4 gemm
003100B3 1 0 0 00 01 0 00 0 0 0 1 1 01 0 0 0 basic_alu
00032203 1 0 0 00 02 1 01 0 0 0 1 2 04 0 0 0 basic_load
00838063 1 0 0 00 04 1 04 0 0 0 1 3 00 0 0 0 basic_branch
31250077 1 0 0 00 10 0 00 0 0 0 1 5 03 0 0 0 basic_gemm
60048007 1 0 0 00 08 0 00 1 3 0 1 4 06 0 0 0 basic_mload
00000000 0 0 0 00 00 0 00 1 6 0 0 4 06 0 0 0 idle_wb
00053283 1 0 0 00 02 0 00 0 0 0 1 2 05 0 0 0 waw_load
000286B3 1 0 0 00 01 0 00 0 0 0 1 1 0D 3 0 0 raw_load_tag
00C582B3 1 0 0 00 01 0 00 0 0 1 0 1 0D 3 0 0 waw_stall
00C582B3 1 0 0 00 01 1 05 0 0 1 0 1 0D 3 0 0 waw_stall_wb
00C582B3 1 0 0 00 01 1 0D 0 0 0 1 1 05 0 0 0 waw_release
789A0077 1 0 0 10 10 0 00 0 0 1 0 1 05 0 0 0 struct_stall
789A0077 1 0 0 10 10 0 00 0 0 1 0 1 05 0 0 0 struct_stall2
789A0077 1 0 0 0F 1F 0 00 0 0 0 1 5 07 0 0 0 struct_release
B7120077 1 0 0 00 10 0 00 1 7 0 1 5 0B 2 0 0 same_edge_wb
C7000077 1 0 0 00 10 0 00 1 B 0 1 5 0C 0 0 0 after_wb_clear
00208A33 1 1 0 00 01 0 00 0 0 0 0 5 0C 0 0 0 freeze_hold
00208A33 1 0 0 00 01 0 00 0 0 0 1 1 14 0 0 0 freeze_release
00018A83 1 0 1 00 02 1 14 0 0 0 0 0 00 0 0 0 flush_squash
00418AB3 1 0 0 00 01 0 00 0 0 0 1 1 15 0 0 0 flush_no_waw
00000AFF 1 0 0 00 00 0 00 0 0 0 0 1 15 0 0 0 illegal_op
FFFFFFFF 1 0 0 00 00 0 00 0 0 0 0 1 15 0 0 0 illegal_all_ones
00000000 0 0 0 00 00 1 15 0 0 0 0 1 15 0 0 0 idle_end
